//--- dma_ctrl_consts.svh
/*
 * DMA control register block constants
 * field widths, register block codes and channel field offsets
 */
`ifndef DMA_CTRL_CONSTS_SVH
`define DMA_CTRL_CONSTS_SVH

// descriptor fields
`define DMA_CTRL_PCIE_ADDR_W 64
`define DMA_CTRL_AXI_ADDR_W 32
`define DMA_CTRL_LEN_W 16
`define DMA_CTRL_TAG_W 8

// register port
`define DMA_CTRL_AXIL_ADDR_W 16
`define DMA_CTRL_AXIL_DATA_W 32

// block codes, address bits 15..8
`define DMA_CTRL_BLK_GLOBAL 8'h00
`define DMA_CTRL_BLK_RD 8'h01
`define DMA_CTRL_BLK_WR 8'h02
`define DMA_CTRL_BLK_CNT 8'h04

// offsets within a block
`define DMA_CTRL_OFS_ENABLE 8'h00
`define DMA_CTRL_OFS_PADDR_LO 8'h00
`define DMA_CTRL_OFS_PADDR_HI 8'h04
`define DMA_CTRL_OFS_AADDR 8'h08
`define DMA_CTRL_OFS_LEN 8'h10
`define DMA_CTRL_OFS_TAG 8'h14
`define DMA_CTRL_OFS_STATUS 8'h18

`define DMA_CTRL_STATUS_VALID_BIT 31

// error merge
`define DMA_CTRL_ERR_SRC 3
`define DMA_CTRL_ERR_CNT_W 4

`endif

//--- dma_ctrl_pkg.sv
/*
 * DMA control types
 * vector types for the descriptor and register fields, the register
 * write bundle, stream beat flags and the register block select
 */
`default_nettype none

`include "dma_ctrl_consts.svh"

package dma_ctrl_pkg;

    typedef logic [`DMA_CTRL_PCIE_ADDR_W-1:0] pcie_addr_t;
    typedef logic [`DMA_CTRL_AXI_ADDR_W-1:0]  axi_addr_t;
    typedef logic [`DMA_CTRL_LEN_W-1:0]       dma_len_t;
    typedef logic [`DMA_CTRL_TAG_W-1:0]       dma_tag_t;

    typedef logic [`DMA_CTRL_AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`DMA_CTRL_AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [7:0]                       reg_ofs_t;

    // saturating error count
    typedef logic [`DMA_CTRL_ERR_CNT_W-1:0]   err_cnt_t;

    typedef struct packed {
        pcie_addr_t pcie_addr;
        axi_addr_t  axi_addr;
        dma_len_t   len;
        dma_tag_t   tag;
    } desc_t;

    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } stream_beat_t;

    // one accepted register write, steered to a single block
    typedef struct packed {
        logic       stb;
        reg_ofs_t   ofs;
        axil_data_t data;
    } reg_wr_t;

    typedef enum logic [2:0] {
        blk_global,
        blk_rd,
        blk_wr,
        blk_cnt,
        blk_none
    } reg_block_e;

endpackage

`default_nettype wire

//--- ctrl_regs.sv
/*
 * DMA control register slave
 * AXI-lite write and read handshakes, block decode, write and read
 * steering to the channel and counter blocks, DMA enable register and
 * registered read data
 */
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_consts.svh"

module ctrl_regs (
    input  logic                    clk,
    input  logic                    rst,

    input  dma_ctrl_pkg::axil_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  dma_ctrl_pkg::axil_data_t wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid,
    input  logic                    bready,
    input  dma_ctrl_pkg::axil_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output dma_ctrl_pkg::axil_data_t rdata,
    output logic                    rvalid,
    input  logic                    rready,

    output dma_ctrl_pkg::reg_wr_t   rd_wr,
    output dma_ctrl_pkg::reg_wr_t   wr_wr,
    output logic                    rd_rd_stb,
    output logic                    wr_rd_stb,
    output dma_ctrl_pkg::reg_ofs_t  rd_ofs,
    input  dma_ctrl_pkg::axil_data_t rd_word,
    input  dma_ctrl_pkg::axil_data_t wr_word,
    input  dma_ctrl_pkg::axil_data_t cnt_word,

    output logic                    dma_enable
);

    import dma_ctrl_pkg::*;

    function automatic reg_block_e decode_block(input axil_addr_t addr);
        reg_block_e blk;
        case (addr[15:8])
            `DMA_CTRL_BLK_GLOBAL: blk = blk_global;
            `DMA_CTRL_BLK_RD:     blk = blk_rd;
            `DMA_CTRL_BLK_WR:     blk = blk_wr;
            `DMA_CTRL_BLK_CNT:    blk = blk_cnt;
            default:              blk = blk_none;
        endcase
        return blk;
    endfunction

    reg_block_e wr_blk;
    reg_block_e rd_blk;
    reg_ofs_t   wr_ofs;
    logic       wr_accept;
    logic       rd_accept;
    axil_data_t rdata_mux;

    // one transaction in flight per direction
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;

    assign wr_blk = decode_block(awaddr);
    assign rd_blk = decode_block(araddr);

    // word aligned offsets
    assign wr_ofs = reg_ofs_t'(awaddr[7:0] & 8'hfc);
    assign rd_ofs = reg_ofs_t'(araddr[7:0] & 8'hfc);

    assign rd_wr = '{stb: wr_accept && (wr_blk == blk_rd), ofs: wr_ofs, data: wdata};
    assign wr_wr = '{stb: wr_accept && (wr_blk == blk_wr), ofs: wr_ofs, data: wdata};

    assign rd_rd_stb = rd_accept && (rd_blk == blk_rd);
    assign wr_rd_stb = rd_accept && (rd_blk == blk_wr);

    always_comb begin
        case (rd_blk)
            blk_global: begin
                if (rd_ofs == `DMA_CTRL_OFS_ENABLE) begin
                    rdata_mux = axil_data_t'(dma_enable);
                end else begin
                    rdata_mux = '0;
                end
            end
            blk_rd:  rdata_mux = rd_word;
            blk_wr:  rdata_mux = wr_word;
            blk_cnt: rdata_mux = cnt_word;
            default: rdata_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            dma_enable <= 1'b0;
        end else begin
            awready <= wr_accept;
            wready  <= wr_accept;
            arready <= rd_accept;
            bvalid  <= wr_accept || (bvalid && !bready);
            rvalid  <= rd_accept || (rvalid && !rready);

            if (wr_accept && wr_blk == blk_global && wr_ofs == `DMA_CTRL_OFS_ENABLE) begin
                dma_enable <= wdata[0];
            end
        end
    end

    // held until the response is taken
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rdata_mux;
        end
    end

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid);

    rdata_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> $stable(rdata));

endmodule

`default_nettype wire

//--- desc_stage.sv
/*
 * DMA descriptor channel
 * stages descriptor fields from register writes, launches the
 * descriptor on a tag write and pops the completion status on a
 * status read
 */
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_consts.svh"

module desc_stage (
    input  logic                     clk,
    input  logic                     rst,

    input  dma_ctrl_pkg::reg_wr_t    reg_wr,
    input  logic                     rd_stb,
    input  dma_ctrl_pkg::reg_ofs_t   rd_ofs,
    output dma_ctrl_pkg::axil_data_t rd_word,

    output dma_ctrl_pkg::desc_t      desc,
    output logic                     desc_valid,
    input  logic                     desc_ready,

    input  dma_ctrl_pkg::dma_tag_t   status_tag,
    input  logic                     status_valid,
    output logic                     status_ready
);

    import dma_ctrl_pkg::*;

    logic launch;
    logic pop;

    assign launch = reg_wr.stb && (reg_wr.ofs == `DMA_CTRL_OFS_TAG);
    assign pop    = rd_stb && (rd_ofs == `DMA_CTRL_OFS_STATUS) && status_valid;

    always_ff @(posedge clk) begin
        if (reg_wr.stb) begin
            case (reg_wr.ofs)
                `DMA_CTRL_OFS_PADDR_LO:
                    desc.pcie_addr[`DMA_CTRL_AXIL_DATA_W-1:0] <= reg_wr.data;
                `DMA_CTRL_OFS_PADDR_HI:
                    desc.pcie_addr[`DMA_CTRL_PCIE_ADDR_W-1:`DMA_CTRL_AXIL_DATA_W] <= reg_wr.data;
                `DMA_CTRL_OFS_AADDR:
                    desc.axi_addr <= reg_wr.data;
                `DMA_CTRL_OFS_LEN:
                    desc.len <= reg_wr.data[`DMA_CTRL_LEN_W-1:0];
                `DMA_CTRL_OFS_TAG:
                    desc.tag <= reg_wr.data[`DMA_CTRL_TAG_W-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid   <= 1'b0;
            status_ready <= 1'b0;
        end else begin
            // a new launch wins over the handshake of the old one
            if (launch) begin
                desc_valid <= 1'b1;
            end else if (desc_ready) begin
                desc_valid <= 1'b0;
            end
            status_ready <= pop;
        end
    end

    // reads 0 while no status is pending
    always_comb begin
        rd_word = '0;
        if (rd_ofs == `DMA_CTRL_OFS_STATUS && status_valid) begin
            rd_word[`DMA_CTRL_TAG_W-1:0]        = status_tag;
            rd_word[`DMA_CTRL_STATUS_VALID_BIT] = 1'b1;
        end
    end

    pop_needs_status: assert property (@(posedge clk) disable iff (rst)
        status_ready |-> $past(status_valid));

endmodule

`default_nettype wire

//--- tlp_counters.sv
/*
 * TLP packet counters
 * counts completed packets on the rq, rc, cq and cc streams and
 * returns the selected count for register reads
 */
`timescale 1ns/1ns
`default_nettype none

module tlp_counters (
    input  logic                         clk,
    input  logic                         rst,

    input  dma_ctrl_pkg::stream_beat_t   rq_beat,
    input  dma_ctrl_pkg::stream_beat_t   rc_beat,
    input  dma_ctrl_pkg::stream_beat_t   cq_beat,
    input  dma_ctrl_pkg::stream_beat_t   cc_beat,

    input  dma_ctrl_pkg::reg_ofs_t       rd_ofs,
    output dma_ctrl_pkg::axil_data_t     rd_word
);

    import dma_ctrl_pkg::*;

    stream_beat_t beat [4];
    axil_data_t   count [4];

    assign beat[0] = rq_beat;
    assign beat[1] = rc_beat;
    assign beat[2] = cq_beat;
    assign beat[3] = cc_beat;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                count[i] <= '0;
            end else if (beat[i].valid && beat[i].ready && beat[i].last) begin
                count[i] <= count[i] + 1'b1;
            end
        end
    end

    always_comb begin
        case (rd_ofs)
            8'h00:   rd_word = count[0];
            8'h04:   rd_word = count[1];
            8'h08:   rd_word = count[2];
            8'h0c:   rd_word = count[3];
            default: rd_word = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- error_pulse_merge.sv
/*
 * Error pulse merge
 * collects simultaneous error pulses into a saturating count and
 * replays them as a train of single-cycle pulses
 */
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_consts.svh"

module error_pulse_merge #(
    parameter int INPUT_WIDTH = `DMA_CTRL_ERR_SRC
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INPUT_WIDTH-1:0] pulse_in,
    output logic                   pulse_out
);

    import dma_ctrl_pkg::*;

    localparam int SUM_W = `DMA_CTRL_ERR_CNT_W + $clog2(INPUT_WIDTH + 1);
    localparam err_cnt_t CNT_MAX = '1;

    err_cnt_t         count;
    logic [SUM_W-1:0] sum;

    // drain one, add new arrivals
    always_comb begin
        sum = SUM_W'(count) - SUM_W'(count != '0);
        for (int i = 0; i < INPUT_WIDTH; i++) begin
            sum = sum + SUM_W'(pulse_in[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            pulse_out <= 1'b0;
        end else begin
            count     <= (sum > SUM_W'(CNT_MAX)) ? CNT_MAX : err_cnt_t'(sum);
            pulse_out <= (count != '0);
        end
    end

    no_wrap: assert property (@(posedge clk) disable iff (rst)
        count != '0 |=> int'(count) + 1 >= int'($past(count)));

endmodule

`default_nettype wire

//--- dma_ctrl_top.sv
/*
 * DMA control block top level
 * register slave, read and write descriptor channels, packet
 * counters, error pulse mergers and the completion interrupt
 */
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_consts.svh"

module dma_ctrl_top (
    input  logic                          clk,
    input  logic                          rst,

    input  dma_ctrl_pkg::axil_addr_t      awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  dma_ctrl_pkg::axil_data_t      wdata,
    input  logic                          wvalid,
    output logic                          wready,
    output logic                          bvalid,
    input  logic                          bready,
    input  dma_ctrl_pkg::axil_addr_t      araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output dma_ctrl_pkg::axil_data_t      rdata,
    output logic                          rvalid,
    input  logic                          rready,

    output dma_ctrl_pkg::desc_t           rd_desc,
    output logic                          rd_desc_valid,
    input  logic                          rd_desc_ready,
    input  dma_ctrl_pkg::dma_tag_t        rd_status_tag,
    input  logic                          rd_status_valid,
    output logic                          rd_status_ready,

    output dma_ctrl_pkg::desc_t           wr_desc,
    output logic                          wr_desc_valid,
    input  logic                          wr_desc_ready,
    input  dma_ctrl_pkg::dma_tag_t        wr_status_tag,
    input  logic                          wr_status_valid,
    output logic                          wr_status_ready,

    input  dma_ctrl_pkg::stream_beat_t    rq_beat,
    input  dma_ctrl_pkg::stream_beat_t    rc_beat,
    input  dma_ctrl_pkg::stream_beat_t    cq_beat,
    input  dma_ctrl_pkg::stream_beat_t    cc_beat,

    input  logic [`DMA_CTRL_ERR_SRC-1:0]  err_cor_in,
    input  logic [`DMA_CTRL_ERR_SRC-1:0]  err_uncor_in,

    output logic                          dma_enable,
    output logic                          irq,
    output logic                          err_cor,
    output logic                          err_uncor
);

    import dma_ctrl_pkg::*;

    reg_wr_t    rd_reg_wr;
    reg_wr_t    wr_reg_wr;
    logic       rd_rd_stb;
    logic       wr_rd_stb;
    reg_ofs_t   rd_ofs;
    axil_data_t rd_word;
    axil_data_t wr_word;
    axil_data_t cnt_word;

    // level interrupt while either status waits
    assign irq = rd_status_valid || wr_status_valid;

    ctrl_regs ctrl (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .rd_wr(rd_reg_wr), .wr_wr(wr_reg_wr),
        .rd_rd_stb(rd_rd_stb), .wr_rd_stb(wr_rd_stb), .rd_ofs(rd_ofs),
        .rd_word(rd_word), .wr_word(wr_word), .cnt_word(cnt_word),
        .dma_enable(dma_enable)
    );

    desc_stage rd_chan (
        .clk(clk), .rst(rst),
        .reg_wr(rd_reg_wr), .rd_stb(rd_rd_stb), .rd_ofs(rd_ofs), .rd_word(rd_word),
        .desc(rd_desc), .desc_valid(rd_desc_valid), .desc_ready(rd_desc_ready),
        .status_tag(rd_status_tag), .status_valid(rd_status_valid),
        .status_ready(rd_status_ready)
    );

    desc_stage wr_chan (
        .clk(clk), .rst(rst),
        .reg_wr(wr_reg_wr), .rd_stb(wr_rd_stb), .rd_ofs(rd_ofs), .rd_word(wr_word),
        .desc(wr_desc), .desc_valid(wr_desc_valid), .desc_ready(wr_desc_ready),
        .status_tag(wr_status_tag), .status_valid(wr_status_valid),
        .status_ready(wr_status_ready)
    );

    tlp_counters counters (
        .clk(clk), .rst(rst),
        .rq_beat(rq_beat), .rc_beat(rc_beat), .cq_beat(cq_beat), .cc_beat(cc_beat),
        .rd_ofs(rd_ofs), .rd_word(cnt_word)
    );

    error_pulse_merge #(.INPUT_WIDTH(`DMA_CTRL_ERR_SRC)) cor_merge (
        .clk(clk), .rst(rst), .pulse_in(err_cor_in), .pulse_out(err_cor)
    );

    error_pulse_merge #(.INPUT_WIDTH(`DMA_CTRL_ERR_SRC)) uncor_merge (
        .clk(clk), .rst(rst), .pulse_in(err_uncor_in), .pulse_out(err_uncor)
    );

endmodule

`default_nettype wire

//--- tb_dma_ctrl.sv
/*
 * DMA control block testbench
 * directed tests over the AXI-lite register port: reset values, enable
 * register, descriptor launch, status pop, packet counters and error
 * pulse merging
 */
`timescale 1ns/1ns
`default_nettype none

`include "dma_ctrl_consts.svh"

module tb_dma_ctrl;

    import dma_ctrl_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;

    logic clk;
    logic rst;

    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    logic       wvalid;
    logic       wready;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    logic       rvalid;
    logic       rready;

    desc_t    rd_desc;
    logic     rd_desc_valid;
    logic     rd_desc_ready;
    dma_tag_t rd_status_tag;
    logic     rd_status_valid;
    logic     rd_status_ready;
    desc_t    wr_desc;
    logic     wr_desc_valid;
    logic     wr_desc_ready;
    dma_tag_t wr_status_tag;
    logic     wr_status_valid;
    logic     wr_status_ready;

    stream_beat_t rq_beat;
    stream_beat_t rc_beat;
    stream_beat_t cq_beat;
    stream_beat_t cc_beat;

    logic [`DMA_CTRL_ERR_SRC-1:0] err_cor_in;
    logic [`DMA_CTRL_ERR_SRC-1:0] err_uncor_in;

    logic dma_enable;
    logic irq;
    logic err_cor;
    logic err_uncor;

    // output pulse tallies, sampled mid-cycle
    int rd_pops = 0;
    int wr_pops = 0;
    int cor_pulses = 0;
    int uncor_pulses = 0;

    dma_ctrl_top UUT (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .rd_desc(rd_desc), .rd_desc_valid(rd_desc_valid), .rd_desc_ready(rd_desc_ready),
        .rd_status_tag(rd_status_tag), .rd_status_valid(rd_status_valid),
        .rd_status_ready(rd_status_ready),
        .wr_desc(wr_desc), .wr_desc_valid(wr_desc_valid), .wr_desc_ready(wr_desc_ready),
        .wr_status_tag(wr_status_tag), .wr_status_valid(wr_status_valid),
        .wr_status_ready(wr_status_ready),
        .rq_beat(rq_beat), .rc_beat(rc_beat), .cq_beat(cq_beat), .cc_beat(cc_beat),
        .err_cor_in(err_cor_in), .err_uncor_in(err_uncor_in),
        .dma_enable(dma_enable), .irq(irq), .err_cor(err_cor), .err_uncor(err_uncor)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (rd_status_ready) rd_pops++;
        if (wr_status_ready) wr_pops++;
        if (err_cor) cor_pulses++;
        if (err_uncor) uncor_pulses++;
    end

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("RESULT: FAIL");
        $fatal(1, "handshake timeout");
    endtask

    task automatic check_data(input string what, input axil_data_t got, input axil_data_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_desc(input string what, input desc_t got, input desc_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "descriptor mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "signal mismatch");
        end
    endtask

    function automatic axil_addr_t reg_addr(input logic [7:0] blk, input reg_ofs_t ofs);
        return {blk, ofs};
    endfunction

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
        int waited;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) report_timeout("awready and wready");
        end while (!(awready && wready));
        awvalid = 1'b0;
        wvalid = 1'b0;
        waited = 0;
        while (!bvalid) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) report_timeout("bvalid");
        end
        bready = 1'b1;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        int waited;
        araddr = addr;
        arvalid = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) report_timeout("arready");
        end while (!arready);
        arvalid = 1'b0;
        waited = 0;
        while (!rvalid) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) report_timeout("rvalid");
        end
        data = rdata;
        // stall the response, the data must hold
        repeat ($urandom_range(3, 0)) begin
            @(posedge clk);
            #1;
            check_bit("rvalid under back-pressure", rvalid, 1'b1);
            check_data("rdata under back-pressure", rdata, data);
        end
        rready = 1'b1;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic read_expect(input axil_addr_t addr, input axil_data_t exp, input string what);
        axil_data_t got;
        axil_read(addr, got);
        check_data(what, got, exp);
    endtask

    task automatic reset_state_test();
        check_bit("awready", awready, 1'b0);
        check_bit("wready", wready, 1'b0);
        check_bit("bvalid", bvalid, 1'b0);
        check_bit("arready", arready, 1'b0);
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("rd_desc_valid", rd_desc_valid, 1'b0);
        check_bit("wr_desc_valid", wr_desc_valid, 1'b0);
        check_bit("rd_status_ready", rd_status_ready, 1'b0);
        check_bit("wr_status_ready", wr_status_ready, 1'b0);
        check_bit("dma_enable", dma_enable, 1'b0);
        check_bit("err_cor", err_cor, 1'b0);
        check_bit("err_uncor", err_uncor, 1'b0);
        check_bit("irq", irq, 1'b0);
        read_expect(16'h0000, '0, "enable after reset");
        for (int i = 0; i < 4; i++) begin
            read_expect(reg_addr(`DMA_CTRL_BLK_CNT, reg_ofs_t'(i * 4)), '0, "counter after reset");
        end
    endtask

    task automatic enable_test();
        axil_write(16'h0000, 32'h1);
        check_bit("dma_enable set", dma_enable, 1'b1);
        read_expect(16'h0000, 32'h1, "enable readback set");
        axil_write(16'h0000, 32'h0);
        check_bit("dma_enable clear", dma_enable, 1'b0);
        read_expect(16'h0000, 32'h0, "enable readback clear");
        read_expect(16'h0300, '0, "unmapped block");
        read_expect(16'h00f0, '0, "unmapped global offset");
    endtask

    task automatic desc_launch_test(input bit is_wr);
        logic [7:0] blk;
        axil_data_t lo;
        axil_data_t hi;
        axil_data_t aaddr;
        axil_data_t len_word;
        axil_data_t tag_word;
        desc_t      exp;
        int         hold;
        blk = is_wr ? `DMA_CTRL_BLK_WR : `DMA_CTRL_BLK_RD;
        lo = $urandom();
        hi = $urandom();
        aaddr = $urandom();
        len_word = $urandom();
        tag_word = $urandom();
        exp.pcie_addr = {hi, lo};
        exp.axi_addr = aaddr;
        exp.len = len_word[15:0];
        exp.tag = tag_word[7:0];
        axil_write(reg_addr(blk, `DMA_CTRL_OFS_PADDR_LO), lo);
        axil_write(reg_addr(blk, `DMA_CTRL_OFS_PADDR_HI), hi);
        axil_write(reg_addr(blk, `DMA_CTRL_OFS_AADDR), aaddr);
        axil_write(reg_addr(blk, `DMA_CTRL_OFS_LEN), len_word);
        check_bit("desc_valid before launch", is_wr ? wr_desc_valid : rd_desc_valid, 1'b0);
        axil_write(reg_addr(blk, `DMA_CTRL_OFS_TAG), tag_word);
        check_bit("desc_valid after launch", is_wr ? wr_desc_valid : rd_desc_valid, 1'b1);
        check_desc("launched descriptor", is_wr ? wr_desc : rd_desc, exp);
        hold = $urandom_range(8, 1);
        repeat (hold) begin
            @(posedge clk);
            #1;
            check_bit("desc_valid held", is_wr ? wr_desc_valid : rd_desc_valid, 1'b1);
            check_bit("other desc_valid", is_wr ? rd_desc_valid : wr_desc_valid, 1'b0);
        end
        if (is_wr) wr_desc_ready = 1'b1;
        else rd_desc_ready = 1'b1;
        @(posedge clk);
        #1;
        wr_desc_ready = 1'b0;
        rd_desc_ready = 1'b0;
        check_bit("desc_valid after ready", is_wr ? wr_desc_valid : rd_desc_valid, 1'b0);
        check_bit("other desc_valid", is_wr ? rd_desc_valid : wr_desc_valid, 1'b0);
    endtask

    task automatic status_pop_test(input bit is_wr);
        logic [7:0] blk;
        dma_tag_t   tag;
        axil_data_t exp;
        int         pops_before;
        blk = is_wr ? `DMA_CTRL_BLK_WR : `DMA_CTRL_BLK_RD;
        tag = dma_tag_t'($urandom());
        pops_before = is_wr ? wr_pops : rd_pops;
        if (is_wr) begin
            wr_status_tag = tag;
            wr_status_valid = 1'b1;
        end else begin
            rd_status_tag = tag;
            rd_status_valid = 1'b1;
        end
        #1;
        check_bit("irq with status pending", irq, 1'b1);
        exp = '0;
        exp[`DMA_CTRL_STATUS_VALID_BIT] = 1'b1;
        exp[`DMA_CTRL_TAG_W-1:0] = tag;
        read_expect(reg_addr(blk, `DMA_CTRL_OFS_STATUS), exp, "pending status word");
        repeat (2) @(posedge clk);
        #1;
        check_data("status_ready pulses", axil_data_t'((is_wr ? wr_pops : rd_pops) - pops_before),
                   32'd1);
        wr_status_valid = 1'b0;
        rd_status_valid = 1'b0;
        #1;
        check_bit("irq after status taken", irq, 1'b0);
        read_expect(reg_addr(blk, `DMA_CTRL_OFS_STATUS), '0, "idle status word");
        check_data("status_ready pulses", axil_data_t'((is_wr ? wr_pops : rd_pops) - pops_before),
                   32'd1);
    endtask

    task automatic packet_count_test();
        int unsigned  exp_ends [4];
        stream_beat_t beat [4];
        int           cycles;
        for (int i = 0; i < 4; i++) exp_ends[i] = 0;
        cycles = $urandom_range(60, 20);
        repeat (cycles) begin
            for (int i = 0; i < 4; i++) begin
                beat[i] = stream_beat_t'(3'($urandom()));
                if (beat[i].valid && beat[i].ready && beat[i].last) exp_ends[i]++;
            end
            rq_beat = beat[0];
            rc_beat = beat[1];
            cq_beat = beat[2];
            cc_beat = beat[3];
            @(posedge clk);
            #1;
        end
        rq_beat = '0;
        rc_beat = '0;
        cq_beat = '0;
        cc_beat = '0;
        for (int i = 0; i < 4; i++) begin
            read_expect(reg_addr(`DMA_CTRL_BLK_CNT, reg_ofs_t'(i * 4)), exp_ends[i],
                        "packet counter");
        end
    endtask

    task automatic error_merge_test();
        logic [`DMA_CTRL_ERR_SRC-1:0] pat;
        int cor_sent;
        int uncor_sent;
        int cor_before;
        int uncor_before;
        cor_sent = 0;
        uncor_sent = 0;
        cor_before = cor_pulses;
        uncor_before = uncor_pulses;
        repeat (12) begin
            pat = `DMA_CTRL_ERR_SRC'($urandom());
            // stay below the saturation point
            if (cor_sent + $countones(pat) < 15) begin
                err_cor_in = pat;
                cor_sent += $countones(pat);
            end else begin
                err_cor_in = '0;
            end
            pat = `DMA_CTRL_ERR_SRC'($urandom());
            if (uncor_sent + $countones(pat) < 15) begin
                err_uncor_in = pat;
                uncor_sent += $countones(pat);
            end else begin
                err_uncor_in = '0;
            end
            @(posedge clk);
            #1;
        end
        err_cor_in = '0;
        err_uncor_in = '0;
        repeat (40) @(posedge clk);
        #1;
        check_data("err_cor pulses", axil_data_t'(cor_pulses - cor_before), axil_data_t'(cor_sent));
        check_data("err_uncor pulses", axil_data_t'(uncor_pulses - uncor_before),
                   axil_data_t'(uncor_sent));
    endtask

    initial begin
        void'($urandom(32'h4b7a5c02));
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rd_desc_ready = 1'b0;
        rd_status_tag = '0;
        rd_status_valid = 1'b0;
        wr_desc_ready = 1'b0;
        wr_status_tag = '0;
        wr_status_valid = 1'b0;
        rq_beat = '0;
        rc_beat = '0;
        cq_beat = '0;
        cc_beat = '0;
        err_cor_in = '0;
        err_uncor_in = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_state_test();
        enable_test();
        desc_launch_test(1'b0);
        desc_launch_test(1'b1);
        status_pop_test(1'b0);
        status_pop_test(1'b1);
        packet_count_test();
        error_merge_test();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
dma_ctrl_pkg.sv
ctrl_regs.sv
desc_stage.sv
tlp_counters.sv
error_pulse_merge.sv
dma_ctrl_top.sv
tb_dma_ctrl.sv

//--- Makefile
TOP = tb_dma_ctrl
OBJ = obj_dir

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) \
		--Mdir $(OBJ) -o V$(TOP)
	./$(OBJ)/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module dma_ctrl_top

clean:
	rm -rf $(OBJ)
